// ==== rtl/rom_cfg_pkg.sv ====
// Address, queue and client width settings shared by every stage of the ROM fetch subsystem
`default_nettype none

package rom_cfg_pkg;

    // ************************************************************
    // client address space
    // ************************************************************

    localparam int ADDR_W = 20;                     // byte address width seen by the clients

    typedef logic [ADDR_W-1:0] rom_addr_t;          // byte address, or word-aligned request address

    // ************************************************************
    // request queue and credits
    // ************************************************************

    localparam int QUEUE_DEPTH = 4;                 // request queue entries, also the initial credits

    // must hold every value from 0 up to QUEUE_DEPTH
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_t;

    // ************************************************************
    // client data widths
    // ************************************************************

    localparam int SLOT0_DW = 8;                    // byte client, e.g. a CPU program ROM
    localparam int SLOT1_DW = 16;                   // halfword client, e.g. a tile ROM

endpackage

`default_nettype wire

// ==== rtl/rom_bus_pkg.sv ====
// Word, tag and slot state types carried on the fetch bus between slots, arbiter and memory
`default_nettype none

package rom_bus_pkg;

    // one word of the external memory, always fetched whole
    typedef logic [31:0] mem_word_t;

    // index of the slot that owns a request, travels with it to the return path
    typedef logic [0:0] slot_tag_t;

    // ************************************************************
    // slot fetch state
    // ************************************************************

    typedef enum logic [1:0] {
        IDLE      = 2'd0,                           // cache empty, nothing requested since reset
        READY     = 2'd1,                           // no miss outstanding
        WAIT_FILL = 2'd2                            // miss granted, waiting for the word
    } slot_state_e;

endpackage

`default_nettype wire

// ==== rtl/rom_slot_cache.sv ====
// Two-entry word cache for one ROM client; serves hits, asks for missing words, picks the data lane
`timescale 1ns/100ps
`default_nettype none

module rom_slot_cache #(
    parameter int DW = 8                                    // client data width, 8, 16 or 32
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire rom_cfg_pkg::rom_addr_t addr,               // client byte address
    input  wire                       addr_ok,              // addr is valid, held until data_ok
    input  wire                       fill_hit,             // returned word belongs to this slot
    input  wire rom_bus_pkg::mem_word_t fill_data,
    input  wire                       miss_grant,           // one-cycle pulse from the arbiter
    output logic                      miss_req,
    output rom_cfg_pkg::rom_addr_t    miss_addr,            // word-aligned address of the miss
    output logic                      data_ok,              // strobe, dout is valid
    output logic [DW-1:0]             dout
);

    rom_cfg_pkg::rom_addr_t   word_addr;                    // client address with the lane bits cleared
    rom_cfg_pkg::rom_addr_t   pend_addr;                    // address of the granted miss
    rom_cfg_pkg::rom_addr_t   cached_addr0;
    rom_cfg_pkg::rom_addr_t   cached_addr1;
    rom_bus_pkg::mem_word_t   cached_data0;
    rom_bus_pkg::mem_word_t   cached_data1;
    rom_bus_pkg::mem_word_t   data_mux;
    rom_bus_pkg::slot_state_e state;
    logic                     cache_empty;                  // no fill seen since reset
    logic                     victim;                       // entry replaced by the next fill
    logic                     hit0;
    logic                     hit1;
    logic                     hit;
    logic                     fill_match;                   // fill carries the word the client wants
    logic [DW-1:0]            lane;

    // ************************************************************
    // lookup and miss request
    // ************************************************************

    assign word_addr  = {addr[rom_cfg_pkg::ADDR_W-1:2], 2'b00};
    assign hit0       = !cache_empty && (word_addr == cached_addr0);
    assign hit1       = !cache_empty && (word_addr == cached_addr1);
    assign hit        = hit0 || hit1;
    assign fill_match = fill_hit && (word_addr == pend_addr);

    // masked once granted so only one miss is ever outstanding
    assign miss_req  = addr_ok && !hit && (state != rom_bus_pkg::WAIT_FILL);
    assign miss_addr = word_addr;

    // ************************************************************
    // fetch state, replacement and data strobe
    // ************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= rom_bus_pkg::IDLE;
            cache_empty <= 1'b1;
            victim      <= 1'b0;
            data_ok     <= 1'b0;
        end else begin
            data_ok <= addr_ok && (hit || fill_match);      // one cycle after the hit or the fill
            case (state)
                rom_bus_pkg::IDLE,
                rom_bus_pkg::READY: begin
                    if (miss_grant) state <= rom_bus_pkg::WAIT_FILL;
                end
                rom_bus_pkg::WAIT_FILL: begin
                    if (fill_hit) state <= rom_bus_pkg::READY;
                end
                default: state <= rom_bus_pkg::IDLE;
            endcase
            if (fill_hit) begin
                cache_empty <= 1'b0;
                if (!cache_empty) victim <= ~victim;        // first fill leaves the pointer on entry 0
            end
        end
    end

    // cache contents, the first fill writes both entries
    always_ff @(posedge clk) begin
        if (miss_grant) pend_addr <= word_addr;
        if (fill_hit) begin
            if (cache_empty || !victim) begin
                cached_addr0 <= pend_addr;
                cached_data0 <= fill_data;
            end
            if (cache_empty || victim) begin
                cached_addr1 <= pend_addr;
                cached_data1 <= fill_data;
            end
        end
    end

    // ************************************************************
    // lane select
    // ************************************************************

    // a fresh word bypasses the entries, one cycle less on a miss
    assign data_mux = fill_match ? fill_data : (hit0 ? cached_data0 : cached_data1);

    generate
        if (DW == 8) begin : g_byte
            always_comb lane = data_mux[{addr[1:0], 3'b000} +: DW];   // byte lane from addr[1:0]
        end else if (DW == 16) begin : g_half
            always_comb lane = data_mux[{addr[1], 4'b0000} +: DW];    // halfword lane from addr[1]
        end else begin : g_word
            always_comb lane = data_mux;                              // whole word, no lane bits
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (addr_ok && (hit || fill_match)) dout <= lane;
    end

endmodule

`default_nettype wire

// ==== rtl/rom_req_arbiter.sv ====
// Round-robin arbiter that merges the slot misses into one credit-limited issue stream
`timescale 1ns/100ps
`default_nettype none

module rom_req_arbiter #(
    parameter int DEPTH = rom_cfg_pkg::QUEUE_DEPTH          // request queue entries downstream
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req0,
    input  wire rom_cfg_pkg::rom_addr_t addr0,
    input  wire                         req1,
    input  wire rom_cfg_pkg::rom_addr_t addr1,
    input  wire                         credit_return,      // one queue entry freed downstream
    output logic                        grant0,             // one-cycle pulses
    output logic                        grant1,
    output logic                        issue_valid,
    output rom_cfg_pkg::rom_addr_t      issue_addr,
    output rom_bus_pkg::slot_tag_t      issue_tag
);

    rom_cfg_pkg::credit_t credits;                          // free entries in the request queue
    logic                 prio;                             // 1 gives slot 1 first pick
    logic                 has_credit;
    logic                 grant_any;

    // ************************************************************
    // grant
    // ************************************************************

    assign has_credit = (credits != '0);

    always_comb begin
        grant0 = 1'b0;
        grant1 = 1'b0;
        if (has_credit) begin
            if (req0 && (!req1 || !prio)) grant0 = 1'b1;    // slot 0 alone or holding priority
            else if (req1)                grant1 = 1'b1;
        end
    end

    assign grant_any = grant0 || grant1;

    // ************************************************************
    // credits, priority and issue register
    // ************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits     <= rom_cfg_pkg::credit_t'(DEPTH);
            prio        <= 1'b0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= grant_any;
            case ({grant_any, credit_return})
                2'b10:   credits <= credits - 1'b1;         // issue only
                2'b01:   credits <= credits + 1'b1;         // return only
                default: credits <= credits;                // none, or both cancel out
            endcase
            if (grant_any) prio <= grant0;                  // the other slot goes first next time
        end
    end

    always_ff @(posedge clk) begin
        if (grant_any) begin
            issue_addr <= grant1 ? addr1 : addr0;
            issue_tag  <= rom_bus_pkg::slot_tag_t'(grant1);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rom_mem_req.sv ====
// Memory request stage; queues issued misses, drives the external read port, tags returned words
`timescale 1ns/100ps
`default_nettype none

module rom_mem_req #(
    parameter int DEPTH = rom_cfg_pkg::QUEUE_DEPTH          // entries in each queue
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         issue_valid,
    input  wire rom_cfg_pkg::rom_addr_t issue_addr,
    input  wire rom_bus_pkg::slot_tag_t issue_tag,
    input  wire                         mem_ready,          // external port takes a read this cycle
    input  wire                         mem_rvalid,         // one pulse per read, in order
    input  wire rom_bus_pkg::mem_word_t mem_rdata,
    output logic                        credit_return,
    output logic                        mem_rd,
    output rom_cfg_pkg::rom_addr_t      mem_addr,
    output logic                        fill_valid,
    output rom_bus_pkg::slot_tag_t      fill_tag,
    output rom_bus_pkg::mem_word_t      fill_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rom_cfg_pkg::rom_addr_t rq_addr [DEPTH];                // request queue storage
    rom_bus_pkg::slot_tag_t rq_tag  [DEPTH];
    logic [PTR_W-1:0]       rq_wr;
    logic [PTR_W-1:0]       rq_rd;
    logic [CNT_W-1:0]       rq_cnt;
    rom_bus_pkg::slot_tag_t tq_tag  [DEPTH];                // owners of the in-flight reads
    logic [PTR_W-1:0]       tq_wr;
    logic [PTR_W-1:0]       tq_rd;

    // pointer step with wrap at DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ************************************************************
    // request queue
    // ************************************************************

    // credits upstream guarantee a free entry for every issue
    assign mem_rd        = (rq_cnt != '0) && mem_ready;
    assign mem_addr      = rq_addr[rq_rd];
    assign credit_return = mem_rd;                          // each pop frees one entry

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rq_wr  <= '0;
            rq_rd  <= '0;
            rq_cnt <= '0;
        end else begin
            if (issue_valid) rq_wr <= ptr_inc(rq_wr);
            if (mem_rd)      rq_rd <= ptr_inc(rq_rd);
            case ({issue_valid, mem_rd})
                2'b10:   rq_cnt <= rq_cnt + 1'b1;
                2'b01:   rq_cnt <= rq_cnt - 1'b1;
                default: rq_cnt <= rq_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rq_addr[rq_wr] <= issue_addr;
            rq_tag[rq_wr]  <= issue_tag;
        end
    end

    // ************************************************************
    // in-flight tag queue
    // ************************************************************

    // each slot keeps one miss outstanding, so at most two reads are in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tq_wr <= '0;
            tq_rd <= '0;
        end else begin
            if (mem_rd)     tq_wr <= ptr_inc(tq_wr);
            if (mem_rvalid) tq_rd <= ptr_inc(tq_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rd) tq_tag[tq_wr] <= rq_tag[rq_rd];         // owner follows the read out
    end

    // return path, same cycle as the memory answer
    assign fill_valid = mem_rvalid;
    assign fill_tag   = tq_tag[tq_rd];
    assign fill_data  = mem_rdata;

endmodule

`default_nettype wire

// ==== rtl/rom_fetch_top.sv ====
// ROM fetch top level; two client slots share one external read port through arbiter and queue
`timescale 1ns/100ps
`default_nettype none

module rom_fetch_top #(
    parameter int ADDR_W      = rom_cfg_pkg::ADDR_W,
    parameter int QUEUE_DEPTH = rom_cfg_pkg::QUEUE_DEPTH,
    parameter int SLOT0_DW    = rom_cfg_pkg::SLOT0_DW,
    parameter int SLOT1_DW    = rom_cfg_pkg::SLOT1_DW
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [ADDR_W-1:0]            addr0,              // slot 0 client
    input  wire                         addr_ok0,
    output logic                        data_ok0,
    output logic [SLOT0_DW-1:0]         dout0,
    input  wire [ADDR_W-1:0]            addr1,              // slot 1 client
    input  wire                         addr_ok1,
    output logic                        data_ok1,
    output logic [SLOT1_DW-1:0]         dout1,
    input  wire                         mem_ready,          // external read port
    input  wire                         mem_rvalid,
    input  wire rom_bus_pkg::mem_word_t mem_rdata,
    output logic                        mem_rd,
    output logic [ADDR_W-1:0]           mem_addr
);

    logic                   miss_req0;
    logic                   miss_req1;
    rom_cfg_pkg::rom_addr_t miss_addr0;
    rom_cfg_pkg::rom_addr_t miss_addr1;
    logic                   grant0;
    logic                   grant1;
    logic                   issue_valid;
    rom_cfg_pkg::rom_addr_t issue_addr;
    rom_bus_pkg::slot_tag_t issue_tag;
    logic                   credit_return;
    logic                   fill_valid;
    rom_bus_pkg::slot_tag_t fill_tag;
    rom_bus_pkg::mem_word_t fill_data;
    logic                   fill_hit0;
    logic                   fill_hit1;

    // ************************************************************
    // client slots
    // ************************************************************

    assign fill_hit0 = fill_valid && (fill_tag == rom_bus_pkg::slot_tag_t'(0));
    assign fill_hit1 = fill_valid && (fill_tag == rom_bus_pkg::slot_tag_t'(1));

    rom_slot_cache #(.DW(SLOT0_DW)) u_slot0 (
        .clk, .rst_n, .addr(addr0), .addr_ok(addr_ok0), .fill_hit(fill_hit0),
        .fill_data, .miss_grant(grant0), .miss_req(miss_req0), .miss_addr(miss_addr0),
        .data_ok(data_ok0), .dout(dout0)
    );

    rom_slot_cache #(.DW(SLOT1_DW)) u_slot1 (
        .clk, .rst_n, .addr(addr1), .addr_ok(addr_ok1), .fill_hit(fill_hit1),
        .fill_data, .miss_grant(grant1), .miss_req(miss_req1), .miss_addr(miss_addr1),
        .data_ok(data_ok1), .dout(dout1)
    );

    // ************************************************************
    // arbiter and memory request stage
    // ************************************************************

    rom_req_arbiter #(.DEPTH(QUEUE_DEPTH)) u_arb (
        .clk, .rst_n, .req0(miss_req0), .addr0(miss_addr0), .req1(miss_req1),
        .addr1(miss_addr1), .credit_return, .grant0, .grant1, .issue_valid,
        .issue_addr, .issue_tag
    );

    rom_mem_req #(.DEPTH(QUEUE_DEPTH)) u_mem_req (
        .clk, .rst_n, .issue_valid, .issue_addr, .issue_tag, .mem_ready, .mem_rvalid,
        .mem_rdata, .credit_return, .mem_rd, .mem_addr, .fill_valid, .fill_tag, .fill_data
    );

endmodule

`default_nettype wire

// ==== sim/tb_rom_fetch.sv ====
// Testbench for the ROM fetch top level; plays the access trace against a random-latency memory model
`timescale 1ns/100ps
`default_nettype none

module tb_rom_fetch;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 8;                        // length of the quiet check after reset
    localparam int MAX_LINES    = 64;
    localparam int COLS         = 5;                        // test, slot, addr, data, read count
    localparam int AW           = rom_cfg_pkg::ADDR_W;

    logic               clk;
    logic               rst_n;
    logic [AW-1:0]      addr0;
    logic               addr_ok0;
    logic [AW-1:0]      addr1;
    logic               addr_ok1;
    logic               mem_ready;
    logic               mem_rvalid;
    logic [31:0]        mem_rdata;
    wire                data_ok0;
    wire  [7:0]         dout0;
    wire                data_ok1;
    wire  [15:0]        dout1;
    wire                mem_rd;
    wire  [AW-1:0]      mem_addr;

    logic [31:0]        trace_mem [MAX_LINES*COLS];
    logic [31:0]        rng_state;
    logic [AW-1:0]      rd_addr_q [$];                      // reads waiting for their answer
    int                 rd_due_q  [$];                      // cycle each answer is due
    int                 cycle;
    int                 rd_count;                           // mem_rd pulses seen so far
    int                 n_lines;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    logic               trace_loaded;

    rom_fetch_top uut (
        .clk(clk), .rst_n(rst_n), .addr0(addr0), .addr_ok0(addr_ok0), .data_ok0(data_ok0),
        .dout0(dout0), .addr1(addr1), .addr_ok1(addr_ok1), .data_ok1(data_ok1), .dout1(dout1),
        .mem_ready(mem_ready), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .mem_rd(mem_rd), .mem_addr(mem_addr)
    );

    // ************************************************************
    // helpers
    // ************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] seed);
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] trace_field(input int line, input int col);
        return trace_mem[line*COLS + col];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    // one client access with addr_ok held until data_ok
    task automatic access_slot(input int slot, input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        if (slot == 0) begin
            addr0    <= addr[AW-1:0];
            addr_ok0 <= 1'b1;
        end else begin
            addr1    <= addr[AW-1:0];
            addr_ok1 <= 1'b1;
        end
        forever begin
            @(negedge clk);                                 // outputs settled mid-cycle
            if ((slot == 0) ? data_ok0 : data_ok1) break;
        end
        data = (slot == 0) ? 32'(dout0) : 32'(dout1);
        @(posedge clk);
        if (slot == 0) addr_ok0 <= 1'b0;
        else           addr_ok1 <= 1'b0;
    endtask

    // ************************************************************
    // clock and memory model
    // ************************************************************

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // answer side returns in order and at most one word per cycle
    always @(posedge clk) begin
        if (rst_n) begin
            cycle = cycle + 1;
            mem_ready <= (next_random() % 4) != 0;          // stall roughly one cycle in four
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= xorshift32(32'(rd_addr_q.pop_front()));
                void'(rd_due_q.pop_front());
            end else begin
                mem_rvalid <= 1'b0;
            end
        end
    end

    // read side picks a latency of 1 to 6 cycles
    always @(negedge clk) begin
        if (mem_rd) begin
            check_value("mem_ready at mem_rd", 32'(mem_ready), 32'd1);  // port stalled
            check_value("mem_addr[1:0]", 32'(mem_addr[1:0]), 32'd0);    // whole words only
            rd_count = rd_count + 1;
            rd_addr_q.push_back(mem_addr);
            rd_due_q.push_back(cycle + 1 + int'(next_random() % 6));
        end
    end

    // watchdog allows 40 cycles per trace line on top of reset and the quiet check
    initial begin
        wait (trace_loaded);
        repeat (n_lines*40 + RESET_CYCLES + IDLE_CYCLES) @(posedge clk);
        $display("timeout, the DUT stopped answering before the trace was done");
        $display("Simulation failed");
        $finish;
    end

    // ************************************************************
    // test sequence
    // ************************************************************

    initial begin
        int          i;
        int          la;
        int          lb;
        int          test_id;
        int          errors_at_start;
        logic [31:0] got_a;
        logic [31:0] got_b;
        rst_n        = 1'b0;
        addr0        = '0;
        addr_ok0     = 1'b0;
        addr1        = '0;
        addr_ok1     = 1'b0;
        mem_ready    = 1'b0;
        mem_rvalid   = 1'b0;
        mem_rdata    = '0;
        rng_state    = 32'h182b16f2;
        cycle        = 0;
        rd_count     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        trace_loaded = 1'b0;
        for (i = 0; i < MAX_LINES*COLS; i++) trace_mem[i] = '0;     // test id 0 marks the end
        $readmemh("sim/rom_fetch_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && trace_field(n_lines, 0) != 0) n_lines++;
        trace_loaded = 1'b1;
        if (n_lines == 0) begin
            $display("trace file is missing or holds no access lines");
            errors = errors + 1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // test 1 checks that nothing moves while no client asks
        errors_at_start = errors;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("data_ok0", 32'(data_ok0), 32'd0);
            check_value("data_ok1", 32'(data_ok1), 32'd0);
            check_value("mem_rd", 32'(mem_rd), 32'd0);
        end
        tests_run = tests_run + 1;
        if (errors != errors_at_start) tests_failed = tests_failed + 1;
        $display("test 1 %s", (errors == errors_at_start) ? "passed" : "FAILED");

        // trace tests where a slot 1 line right after a slot 0 line runs alongside it
        i = 0;
        while (i < n_lines) begin
            test_id         = trace_field(i, 0);
            errors_at_start = errors;
            while (i < n_lines && trace_field(i, 0) == test_id) begin
                la = i;
                lb = i + 1;
                if (lb < n_lines && trace_field(lb, 0) == test_id &&
                    trace_field(la, 1) == 0 && trace_field(lb, 1) == 1) begin
                    fork
                        access_slot(0, trace_field(la, 2), got_a);
                        access_slot(1, trace_field(lb, 2), got_b);
                    join
                    check_value("dout0", got_a, trace_field(la, 3));
                    check_value("dout1", got_b, trace_field(lb, 3));
                    check_value("mem_rd count", 32'(rd_count), trace_field(lb, 4));
                    i = i + 2;
                end else begin
                    access_slot(trace_field(la, 1), trace_field(la, 2), got_a);
                    check_value((trace_field(la, 1) == 0) ? "dout0" : "dout1",
                                got_a, trace_field(la, 3));
                    check_value("mem_rd count", 32'(rd_count), trace_field(la, 4));
                    i = i + 1;
                end
            end
            tests_run = tests_run + 1;
            if (errors != errors_at_start) tests_failed = tests_failed + 1;
            $display("test %0d %s", test_id, (errors == errors_at_start) ? "passed" : "FAILED");
        end

        $display("tests run %0d, tests failed %0d, checks failed %0d, memory reads %0d",
                 tests_run, tests_failed, errors, rd_count);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/rom_fetch_trace.txt ====
// columns, all hex: test id, slot, byte address, expected lane data, expected total mem_rd count
// a slot 1 line right after a slot 0 line of the same test is played at the same time
// test 2, first access misses and fills both entries
2 0 00011 02 01
// test 3, other bytes hit, a second word, then both words hit
3 0 00010 31 01
3 0 00012 42 01
3 0 00013 00 01
3 0 00022 84 02
3 0 00012 42 02
3 0 00021 04 02
3 0 00020 62 02
// test 4, words A B C then A again
4 0 00040 c4 03
4 0 00081 11 04
4 0 00102 20 05
4 0 00083 02 05
4 0 00043 01 06
// test 5, both slots at once under stalls and random latency
5 0 00201 46 08
5 1 00402 1080 08
5 0 00042 08 09
5 1 00800 1880 09
5 0 01003 42 0a
5 1 00400 8c40 0a
5 0 02001 62 0c
5 1 01002 4202 0c
5 0 00004 84 0e
5 1 00012 0042 0e
5 0 02002 04 0e
5 1 01000 3100 0e

// ==== list.f ====
rtl/rom_cfg_pkg.sv
rtl/rom_bus_pkg.sv
rtl/rom_slot_cache.sv
rtl/rom_req_arbiter.sv
rtl/rom_mem_req.sv
rtl/rom_fetch_top.sv
sim/tb_rom_fetch.sv

// ==== Bender.yml ====
package:
  name: rom_fetch

dependencies: {}

sources:
  # packages first, then the stages, then the top level
  - files:
      - rtl/rom_cfg_pkg.sv
      - rtl/rom_bus_pkg.sv
      - rtl/rom_slot_cache.sv
      - rtl/rom_req_arbiter.sv
      - rtl/rom_mem_req.sv
      - rtl/rom_fetch_top.sv
  - target: simulation
    files:
      - sim/tb_rom_fetch.sv
